//--- verilog/pic_pkg.sv
package pic_pkg;

	// --------------------
	// Sizes.
	// --------------------
	localparam int NUM_IRQ = 8;
	localparam int LEVEL_W = 3;
	localparam int DATA_W = 8;

	// --------------------
	// Command word bits.
	// --------------------
	localparam int ICW1_SEL_BIT = 4;
	localparam int OCW3_SEL_BIT = 3;
	localparam int LTIM_BIT = 3;
	localparam int IC4_BIT = 0;
	localparam int AEOI_BIT = 1;
	localparam int POLL_BIT = 2;
	localparam int RR_BIT = 1;
	localparam int RIS_BIT = 0;

	typedef logic [NUM_IRQ-1:0] irq_vec_t;
	typedef logic [LEVEL_W-1:0] irq_level_t;
	typedef logic [DATA_W-1:0] data_t;

	localparam data_t POLL_FLAG = 8'h80;
	localparam irq_level_t SPURIOUS_LEVEL = 3'd7;

	typedef enum logic [1:0] {
		INIT_WAIT_ICW1,
		INIT_WAIT_ICW2,
		INIT_WAIT_ICW4,
		INIT_READY
	} init_state_e;

	typedef enum logic [2:0] {
		ACK_IDLE,
		ACK_FIRST,
		ACK_GAP,
		ACK_SECOND,
		ACK_POLL
	} ack_state_e;

	// Only the EOI codes in OCW2 bits 7..5 are acted on.
	typedef enum logic [2:0] {
		EOI_NONSPEC = 3'b001,
		EOI_SPEC = 3'b011
	} eoi_cmd_e;

endpackage

//--- verilog/init_sequencer.sv
`timescale 1ns/10ps

module init_sequencer
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  logic a0,
	input  data_t din,
	output logic icw1_wr,
	output logic ocw1_wr,
	output logic ocw2_wr,
	output logic ocw3_wr,
	output logic init_ready,
	output logic ltim,
	output logic auto_eoi,
	output logic [DATA_W-LEVEL_W-1:0] vector_base
);

	init_state_e state;
	logic ic4;
	logic ctrl_wr;

	// --------------------
	// Command decode.
	// --------------------
	// ICW1 restarts the sequence from any state.
	assign icw1_wr = wr && !a0 && din[ICW1_SEL_BIT];
	assign ocw1_wr = wr && a0 && (state == INIT_READY);
	assign ctrl_wr = wr && !a0 && !din[ICW1_SEL_BIT] && (state == INIT_READY);
	assign ocw2_wr = ctrl_wr && !din[OCW3_SEL_BIT];
	assign ocw3_wr = ctrl_wr && din[OCW3_SEL_BIT];

	assign init_ready = (state == INIT_READY);

	// --------------------
	// ICW state machine.
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= INIT_WAIT_ICW1;
			ic4 <= 1'b0;
			ltim <= 1'b0;
			auto_eoi <= 1'b0;
			vector_base <= '0;
		end
		else if (icw1_wr)
		begin
			state <= INIT_WAIT_ICW2;
			ltim <= din[LTIM_BIT];
			ic4 <= din[IC4_BIT];
			auto_eoi <= 1'b0;
		end
		else if (wr && a0)
		begin
			case (state)
				INIT_WAIT_ICW2:
				begin
					vector_base <= din[DATA_W-1:LEVEL_W];
					state <= ic4 ? INIT_WAIT_ICW4 : INIT_READY;
				end
				INIT_WAIT_ICW4:
				begin
					auto_eoi <= din[AEOI_BIT];
					state <= INIT_READY;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

//--- verilog/irq_request_reg.sv
`timescale 1ns/10ps

module irq_request_reg
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  irq_vec_t ir,
	input  logic ltim,
	input  logic icw1_wr,
	input  logic take,
	input  irq_level_t take_level,
	output irq_vec_t irr
);

	irq_vec_t ir_meta;
	irq_vec_t ir_sync;
	irq_vec_t ir_prev;
	irq_vec_t take_clr;

	always_comb
	begin
		take_clr = '0;
		if (take)
			take_clr[take_level] = 1'b1;
	end

	// Two flops on the pins, a third for edge detection.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ir_meta <= '0;
			ir_sync <= '0;
			ir_prev <= '0;
		end
		else
		begin
			ir_meta <= ir;
			ir_sync <= ir_meta;
			ir_prev <= ir_sync;
		end
	end

	// --------------------
	// Request register.
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			irr <= '0;
		else if (icw1_wr)
			irr <= '0;
		else if (ltim)
			irr <= ir_sync;
		else
			irr <= (irr & ~take_clr) | (ir_sync & ~ir_prev);
	end

endmodule

//--- verilog/priority_resolver.sv
`timescale 1ns/10ps

module priority_resolver
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  irq_vec_t irr,
	input  irq_vec_t isr,
	input  logic ocw1_wr,
	input  logic icw1_wr,
	input  data_t din,
	output irq_vec_t mask,
	output logic int_pending,
	output irq_level_t int_level
);

	irq_vec_t req;
	logic blocked;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mask <= '0;
		else if (icw1_wr)
			mask <= '0;
		else if (ocw1_wr)
			mask <= din;
	end

	assign req = irr & ~mask;

	// Level 0 wins. An in-service level blocks itself and everything below it.
	always_comb
	begin
		blocked = 1'b0;
		int_pending = 1'b0;
		int_level = '0;
		for (int i = 0; i < NUM_IRQ; i++)
		begin
			if (isr[i])
				blocked = 1'b1;
			if (!blocked && !int_pending && req[i])
			begin
				int_pending = 1'b1;
				int_level = irq_level_t'(i);
			end
		end
	end

endmodule

//--- verilog/in_service_reg.sv
`timescale 1ns/10ps

module in_service_reg
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic take,
	input  logic ocw2_wr,
	input  logic icw1_wr,
	input  logic ack_end,
	input  logic auto_eoi,
	input  irq_level_t take_level,
	input  data_t din,
	output irq_vec_t isr
);

	irq_vec_t isr_set;
	irq_vec_t isr_clr;
	irq_vec_t lowest;
	irq_level_t cur_level;
	logic cur_valid;

	// Lowest set bit is the highest priority in service.
	assign lowest = isr & (~isr + 1'b1);

	always_comb
	begin
		isr_set = '0;
		isr_clr = '0;
		if (take)
			isr_set[take_level] = 1'b1;
		if (ocw2_wr)
		begin
			case (eoi_cmd_e'(din[DATA_W-1 -: 3]))
				EOI_NONSPEC: isr_clr = isr_clr | lowest;
				EOI_SPEC: isr_clr[din[LEVEL_W-1:0]] = 1'b1;
				default:
				begin
				end
			endcase
		end
		if (ack_end && auto_eoi && cur_valid)
			isr_clr[cur_level] = 1'b1;
	end

	// --------------------
	// Registers.
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			isr <= '0;
		else if (icw1_wr)
			isr <= '0;
		else
			isr <= (isr & ~isr_clr) | isr_set;
	end

	// Auto EOI clears the level of the last acknowledge.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cur_level <= '0;
			cur_valid <= 1'b0;
		end
		else if (icw1_wr)
			cur_valid <= 1'b0;
		else if (take)
		begin
			cur_level <= take_level;
			cur_valid <= 1'b1;
		end
		else if (ack_end)
			cur_valid <= 1'b0;
	end

endmodule

//--- verilog/ack_sequencer.sv
`timescale 1ns/10ps

module ack_sequencer
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic inta_n,
	input  logic rd,
	input  logic a0,
	input  logic init_ready,
	input  logic ocw3_wr,
	input  logic icw1_wr,
	input  logic int_pending,
	input  irq_level_t int_level,
	input  data_t din,
	input  irq_vec_t irr,
	input  irq_vec_t isr,
	input  irq_vec_t mask,
	input  logic [DATA_W-LEVEL_W-1:0] vector_base,
	output logic intr,
	output logic take,
	output logic ack_end,
	output logic dout_en,
	output irq_level_t take_level,
	output data_t dout
);

	ack_state_e state;
	logic rd_q;
	logic rd_rise;
	logic rd_fall;
	logic req_ok;
	logic ris_sel;
	logic poll_hit;
	logic poll_busy;

	assign rd_rise = rd && !rd_q;
	assign rd_fall = !rd && rd_q;
	assign req_ok = init_ready && int_pending;

	assign intr = (state == ACK_IDLE) && req_ok;
	assign dout_en = ((state == ACK_SECOND) && !inta_n) || (rd && rd_q);

	// --------------------
	// Acknowledge FSM.
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ACK_IDLE;
			rd_q <= 1'b0;
			ris_sel <= 1'b0;
			poll_hit <= 1'b0;
			poll_busy <= 1'b0;
			take_level <= '0;
			take <= 1'b0;
			ack_end <= 1'b0;
		end
		else
		begin
			rd_q <= rd;
			take <= 1'b0;
			ack_end <= 1'b0;
			if (ocw3_wr && din[RR_BIT])
				ris_sel <= din[RIS_BIT];
			if (icw1_wr)
			begin
				state <= ACK_IDLE;
				ris_sel <= 1'b0;
				poll_busy <= 1'b0;
			end
			else
			begin
				case (state)
					ACK_IDLE:
						if (ocw3_wr && din[POLL_BIT])
							state <= ACK_POLL;
						else if (!inta_n)
						begin
							state <= ACK_FIRST;
							take <= req_ok;
							take_level <= req_ok ? int_level : SPURIOUS_LEVEL;
						end
					ACK_FIRST:
						if (inta_n)
							state <= ACK_GAP;
					ACK_GAP:
						if (!inta_n)
							state <= ACK_SECOND;
					ACK_SECOND:
						if (inta_n)
						begin
							state <= ACK_IDLE;
							ack_end <= 1'b1;
						end
					ACK_POLL:
						// The poll read acts as the acknowledge.
						if (rd_rise && !a0)
						begin
							poll_busy <= 1'b1;
							poll_hit <= req_ok;
							take <= req_ok;
							take_level <= int_level;
						end
						else if (rd_fall && poll_busy)
						begin
							poll_busy <= 1'b0;
							state <= ACK_IDLE;
						end
					default: state <= ACK_IDLE;
				endcase
			end
		end
	end

	// --------------------
	// Read data.
	// --------------------
	always_comb
	begin
		if (state == ACK_SECOND)
			dout = {vector_base, take_level};
		else if ((state == ACK_POLL) && poll_busy)
			dout = poll_hit ? (POLL_FLAG | data_t'(take_level)) : '0;
		else if (a0)
			dout = mask;
		else if (ris_sel)
			dout = isr;
		else
			dout = irr;
	end

endmodule

//--- verilog/pic_top.sv
`timescale 1ns/10ps

module pic_top
	import pic_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  logic rd,
	input  logic a0,
	input  logic inta_n,
	input  data_t din,
	input  irq_vec_t ir,
	output data_t dout,
	output logic dout_en,
	output logic intr
);

	logic icw1_wr;
	logic ocw1_wr;
	logic ocw2_wr;
	logic ocw3_wr;
	logic init_ready;
	logic ltim;
	logic auto_eoi;
	logic [DATA_W-LEVEL_W-1:0] vector_base;
	logic take;
	logic ack_end;
	logic int_pending;
	irq_level_t take_level;
	irq_level_t int_level;
	irq_vec_t irr;
	irq_vec_t isr;
	irq_vec_t mask;

	init_sequencer u_init_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.a0          (a0),
		.din         (din),
		.icw1_wr     (icw1_wr),
		.ocw1_wr     (ocw1_wr),
		.ocw2_wr     (ocw2_wr),
		.ocw3_wr     (ocw3_wr),
		.init_ready  (init_ready),
		.ltim        (ltim),
		.auto_eoi    (auto_eoi),
		.vector_base (vector_base)
	);

	irq_request_reg u_irq_request_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir         (ir),
		.ltim       (ltim),
		.icw1_wr    (icw1_wr),
		.take       (take),
		.take_level (take_level),
		.irr        (irr)
	);

	priority_resolver u_priority_resolver (
		.clk         (clk),
		.rst_n       (rst_n),
		.irr         (irr),
		.isr         (isr),
		.ocw1_wr     (ocw1_wr),
		.icw1_wr     (icw1_wr),
		.din         (din),
		.mask        (mask),
		.int_pending (int_pending),
		.int_level   (int_level)
	);

	in_service_reg u_in_service_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.take       (take),
		.ocw2_wr    (ocw2_wr),
		.icw1_wr    (icw1_wr),
		.ack_end    (ack_end),
		.auto_eoi   (auto_eoi),
		.take_level (take_level),
		.din        (din),
		.isr        (isr)
	);

	ack_sequencer u_ack_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.inta_n      (inta_n),
		.rd          (rd),
		.a0          (a0),
		.init_ready  (init_ready),
		.ocw3_wr     (ocw3_wr),
		.icw1_wr     (icw1_wr),
		.int_pending (int_pending),
		.int_level   (int_level),
		.din         (din),
		.irr         (irr),
		.isr         (isr),
		.mask        (mask),
		.vector_base (vector_base),
		.intr        (intr),
		.take        (take),
		.ack_end     (ack_end),
		.dout_en     (dout_en),
		.take_level  (take_level),
		.dout        (dout)
	);

endmodule

//--- verif/pic_tb_tasks.svh
// The rising edge in the middle samples one wr pulse.
task automatic write_reg(input logic addr, input data_t data);
	@(negedge clk);
	a0 = addr;
	din = data;
	wr = 1'b1;
	@(negedge clk);
	wr = 1'b0;
	din = '0;
endtask

// rd is held two cycles and dout is taken just before rd drops.
task automatic read_reg(input logic addr, output data_t data);
	@(negedge clk);
	a0 = addr;
	rd = 1'b1;
	@(negedge clk);
	@(negedge clk);
	data = dout;
	assert (dout_en === 1'b1)
	else
	begin
		errors++;
		$display("dout_en was low at the end of a register read");
	end
	rd = 1'b0;
endtask

// The vector is taken while the second of two INTA pulses is low.
task automatic pulse_inta(output data_t vec);
	int n;
	@(negedge clk);
	inta_n = 1'b0;
	@(negedge clk);
	inta_n = 1'b1;
	@(negedge clk);
	inta_n = 1'b0;
	@(negedge clk);
	n = 1;
	while (dout_en !== 1'b1 && n < 8)
	begin
		@(negedge clk);
		n++;
	end
	vec = dout;
	assert (dout_en === 1'b1)
	else
	begin
		errors++;
		$display("no vector was driven during the second INTA pulse");
	end
	inta_n = 1'b1;
endtask

task automatic wait_intr(input int limit);
	int n;
	n = 0;
	while (intr !== 1'b1 && n < limit)
	begin
		@(negedge clk);
		n++;
	end
	assert (intr === 1'b1)
	else
	begin
		errors++;
		$display("timed out after %0d cycles waiting for intr", limit);
	end
endtask

//--- verif/pic_tb.sv
`timescale 1ns/10ps

module pic_tb
	import pic_pkg::*;
();

	logic clk;
	logic rst_n;
	logic wr;
	logic rd;
	logic a0;
	logic inta_n;
	data_t din;
	irq_vec_t ir;
	data_t dout;
	logic dout_en;
	logic intr;

	int errors;
	int checks;
	int seed;
	data_t vec_base;
	irq_vec_t isr_model;
	irq_vec_t mask_model;
	irq_vec_t pattern;
	irq_level_t lvl;
	data_t got;

	pic_top u_pic_top (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (wr),
		.rd      (rd),
		.a0      (a0),
		.inta_n  (inta_n),
		.din     (din),
		.ir      (ir),
		.dout    (dout),
		.dout_en (dout_en),
		.intr    (intr)
	);

	always #4 clk = ~clk;

	`include "pic_tb_tasks.svh"

	// --------------------
	// Reference model.
	// --------------------
	// IR0 has the highest priority.
	function automatic irq_level_t top_level(input irq_vec_t v);
		top_level = '0;
		for (int i = NUM_IRQ - 1; i >= 0; i--)
			if (v[i])
				top_level = irq_level_t'(i);
	endfunction

	function automatic irq_vec_t clear_lowest(input irq_vec_t v);
		irq_vec_t r;
		r = v;
		if (v != '0)
			r[top_level(v)] = 1'b0;
		return r;
	endfunction

	function automatic data_t vector_for(input irq_level_t level);
		return {vec_base[7:3], level};
	endfunction

	function automatic data_t poll_word(input irq_vec_t pending);
		if (pending == '0)
			return 8'h00;
		return {5'b10000, top_level(pending)};
	endfunction

	task automatic check_byte(input string name, input data_t got_val, input data_t exp_val);
		checks++;
		assert (got_val === exp_val)
		else
		begin
			errors++;
			$display("mismatch %s: got %h expected %h at %0t", name, got_val, exp_val, $time);
		end
	endtask

	task automatic hold_intr_low(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			check_byte("intr", data_t'(intr), 8'h00);
		end
	endtask

	// --------------------
	// Bus properties.
	// --------------------
	assert property (@(posedge clk) $rose(rst_n) |-> !intr)
	else
	begin
		errors++;
		$display("intr was high when reset was released");
	end

	assert property (@(posedge clk) disable iff (!rst_n) dout_en |-> (!inta_n || rd))
	else
	begin
		errors++;
		$display("dout_en was high with neither INTA nor a read active");
	end

	assert property (@(posedge clk) disable iff (!rst_n) dout_en |-> !$isunknown(dout))
	else
	begin
		errors++;
		$display("dout had unknown bits while dout_en was high");
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		a0 = 1'b0;
		inta_n = 1'b1;
		din = '0;
		ir = '0;
		errors = 0;
		checks = 0;
		seed = 32'h11b;
		vec_base = '0;
		isr_model = '0;
		mask_model = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Edge mode with ICW4, then one request on IR5.
		write_reg(1'b0, 8'h11);
		write_reg(1'b1, 8'h40);
		write_reg(1'b1, 8'h01);
		vec_base = 8'h40;
		ir = 8'h20;
		wait_intr(20);
		pulse_inta(got);
		check_byte("dout", got, vector_for(3'd5));
		isr_model[5] = 1'b1;
		@(negedge clk);
		check_byte("intr", data_t'(intr), 8'h00);
		write_reg(1'b0, 8'h20);
		isr_model = clear_lowest(isr_model);

		// IR3 and IR6 together. IR6 waits behind IR3 until the EOI.
		ir = ir | 8'h48;
		wait_intr(20);
		pulse_inta(got);
		lvl = top_level(8'h48 & ~mask_model);
		check_byte("dout", got, vector_for(lvl));
		isr_model[lvl] = 1'b1;
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, got);
		check_byte("isr", got, isr_model);
		hold_intr_low(10);
		write_reg(1'b0, 8'h20);
		isr_model = clear_lowest(isr_model);
		wait_intr(20);
		pulse_inta(got);
		check_byte("dout", got, vector_for(3'd6));
		isr_model[6] = 1'b1;

		// --------------------
		// Mask.
		// --------------------
		write_reg(1'b1, 8'h04);
		mask_model = 8'h04;
		ir = ir | 8'h04;
		hold_intr_low(20);
		read_reg(1'b1, got);
		check_byte("mask", got, mask_model);
		write_reg(1'b1, 8'h00);
		mask_model = 8'h00;
		wait_intr(20);
		pulse_inta(got);
		check_byte("dout", got, vector_for(3'd2));
		isr_model[2] = 1'b1;

		// Specific EOI for level 6 leaves level 2 in service.
		write_reg(1'b0, 8'h66);
		isr_model[6] = 1'b0;
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, got);
		check_byte("isr", got, isr_model);

		// Auto EOI.
		ir = '0;
		repeat (4) @(negedge clk);
		write_reg(1'b0, 8'h11);
		write_reg(1'b1, 8'h40);
		write_reg(1'b1, 8'h03);
		isr_model = '0;
		mask_model = '0;
		ir = 8'h02;
		wait_intr(20);
		pulse_inta(got);
		check_byte("dout", got, vector_for(3'd1));
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, got);
		check_byte("isr", got, isr_model);

		// --------------------
		// Poll.
		// --------------------
		ir = 8'h10;
		wait_intr(20);
		write_reg(1'b0, 8'h0c);
		read_reg(1'b0, got);
		check_byte("poll", got, poll_word(8'h10));
		isr_model[4] = 1'b1;
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, got);
		check_byte("isr", got, isr_model);
		write_reg(1'b0, 8'h0c);
		read_reg(1'b0, got);
		check_byte("poll", got, poll_word(8'h00));

		// In level mode IRR follows the pins.
		write_reg(1'b0, 8'h18);
		write_reg(1'b1, 8'h40);
		write_reg(1'b0, 8'h0a);
		for (int i = 0; i < 4; i++)
		begin
			pattern = irq_vec_t'($random(seed));
			ir = pattern;
			repeat (4) @(negedge clk);
			read_reg(1'b0, got);
			check_byte("irr", got, pattern);
		end

		repeat (4) @(negedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- src.f
+incdir+verif
verilog/pic_pkg.sv
verilog/init_sequencer.sv
verilog/irq_request_reg.sv
verilog/priority_resolver.sv
verilog/in_service_reg.sv
verilog/ack_sequencer.sv
verilog/pic_top.sv
verif/pic_tb.sv
